//--- Makefile
# Verilator build and run for the I/O clock generator testbench

VERILATOR ?= verilator
TOP       ?= tbIoClk
FILELIST  ?= ioClkGen.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test OK

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only when the pass message appears as a line of its own
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- hdl/clockDivider.sv
`default_nettype none

module clockDivider (
    input  wire logic                              divided_clk_src,
    input  wire logic                              arstN,
    input  wire logic                              queueEmpty,
    input  wire logic [ioClkPkg::configWidth-1:0] headData,
    output logic                                   pop,
    output logic                                   dividedClk,
    output ioClkPkg::outMode_e                     activeMode
);

    logic [ioClkPkg::configWidth-1:0]  activeWord;
    logic [ioClkPkg::divisorWidth-1:0] divisor;
    logic [ioClkPkg::divisorWidth-1:0] divCount;
    logic                              wrap;
    logic                              adoptPoint;
    logic                              clkNext;

    assign divisor    = activeWord[ioClkPkg::divisorWidth-1:0];
    assign activeMode = ioClkPkg::outMode_e'(
        activeWord[ioClkPkg::configWidth-1 -: ioClkPkg::modeWidth]);
    assign wrap       = (divCount == divisor);

    // Running modes only switch at a period boundary
    always_comb begin
        case (activeMode)
            ioClkPkg::modeToggle,
            ioClkPkg::modePulse: adoptPoint = wrap;
            default:             adoptPoint = 1'b1;
        endcase
    end

    assign pop = adoptPoint && !queueEmpty;

    // Output shaping
    always_comb begin
        case (activeMode)
            ioClkPkg::modeToggle: clkNext = wrap ? !dividedClk : dividedClk;
            ioClkPkg::modePulse:  clkNext = wrap;
            default:              clkNext = 1'b0;
        endcase
    end

    always_ff @(posedge divided_clk_src or negedge arstN) begin
        if (!arstN) begin
            activeWord <= '0;
            divCount   <= '0;
            dividedClk <= 1'b0;
        end else if (pop) begin
            // New config starts a fresh period
            activeWord <= headData;
            divCount   <= '0;
            dividedClk <= 1'b0;
        end else begin
            divCount   <= wrap ? '0 : divCount + 1'b1;
            dividedClk <= clkNext;
        end
    end

    counterInRange: assert property (
        @(posedge divided_clk_src) disable iff (!arstN)
        divCount <= divisor
    );

endmodule

`default_nettype wire

//--- hdl/configQueue.sv
`default_nettype none

module configQueue (
    input  wire logic                              divided_clk_src,
    input  wire logic                              arstN,
    input  wire logic                              push,
    input  wire logic [ioClkPkg::configWidth-1:0] pushData,
    input  wire logic                              pop,
    output logic      [ioClkPkg::configWidth-1:0] headData,
    output logic                                   full,
    output logic                                   empty
);

    logic [ioClkPkg::configWidth-1:0]   entries [ioClkPkg::queueDepth];
    logic [ioClkPkg::queuePtrWidth-1:0] wrPtr;
    logic [ioClkPkg::queuePtrWidth-1:0] rdPtr;
    logic [ioClkPkg::queueCntWidth-1:0] count;

    // Circular increment, depth need not be a power of two
    function automatic logic [ioClkPkg::queuePtrWidth-1:0] ptrInc(
        input logic [ioClkPkg::queuePtrWidth-1:0] ptr
    );
        if (int'(ptr) == ioClkPkg::queueDepth - 1) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge divided_clk_src or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= ptrInc(wrPtr);
            end
            if (pop) begin
                rdPtr <= ptrInc(rdPtr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge divided_clk_src) begin
        if (push) begin
            entries[wrPtr] <= pushData;
        end
    end

    assign headData = entries[rdPtr];
    assign full     = (int'(count) == ioClkPkg::queueDepth);
    assign empty    = (count == '0);

    noPushWhenFull: assert property (
        @(posedge divided_clk_src) disable iff (!arstN)
        push |-> !full
    );

    noPopWhenEmpty: assert property (
        @(posedge divided_clk_src) disable iff (!arstN)
        pop |-> !empty
    );

endmodule

`default_nettype wire

//--- hdl/ioClkGenerationCell.sv
`default_nettype none

module ioClkGenerationCell (
    input  wire logic                               divided_clk_src,
    input  wire logic                               arstN,

    input  wire logic                               configAck,
    output logic                                    configReq,
    input  wire logic                               loadEn,
    input  var  ioClkPkg::loadOp_e                  minorOpcode,
    input  wire logic                               addrOffset,
    input  wire logic [ioClkPkg::configWidth-1:0]  configWord,
    input  wire logic [ioClkPkg::regDestWidth-1:0] regDest,

    output logic                                    responseAck,
    input  wire logic                               responseReq,
    output logic      [ioClkPkg::regDestWidth-1:0] responseRegDest,
    output logic      [ioClkPkg::dataWidth-1:0]    responseData,

    output logic                                    dividedClk,
    output ioClkPkg::outMode_e                      activeMode
);

    logic                             writeAccept;
    logic                             queueFull;
    logic                             queueEmpty;
    logic                             queuePop;
    logic [ioClkPkg::configWidth-1:0] queueHead;
    logic [ioClkPkg::configWidth-1:0] committedWord;
    logic [ioClkPkg::dataWidth-1:0]   alignIn;

    // Loads borrow the response handshake, writes wait for queue space
    assign configReq   = loadEn ? responseReq : !queueFull;
    assign writeAccept = configAck && configReq && !loadEn;
    assign responseAck = configAck && loadEn;

    // Committed word for read-back
    always_ff @(posedge divided_clk_src or negedge arstN) begin
        if (!arstN) begin
            committedWord <= '0;
        end else if (writeAccept) begin
            committedWord <= configWord;
        end
    end

    assign alignIn         = committedWord;
    assign responseRegDest = regDest;

    loadDataAlignment loadAlign (
        .minorOpcode (minorOpcode),
        .addrOffset  (addrOffset),
        .dataIn      (alignIn),
        .dataOut     (responseData)
    );

    configQueue pendingQueue (
        .divided_clk_src (divided_clk_src),
        .arstN           (arstN),
        .push            (writeAccept),
        .pushData        (configWord),
        .pop             (queuePop),
        .headData        (queueHead),
        .full            (queueFull),
        .empty           (queueEmpty)
    );

    clockDivider divider (
        .divided_clk_src (divided_clk_src),
        .arstN           (arstN),
        .queueEmpty      (queueEmpty),
        .headData        (queueHead),
        .pop             (queuePop),
        .dividedClk      (dividedClk),
        .activeMode      (activeMode)
    );

    // Bus side must never overrun the queue
    noWriteWhenFull: assert property (
        @(posedge divided_clk_src) disable iff (!arstN)
        queueFull && !queuePop |=> queueFull
    );

endmodule

`default_nettype wire

//--- hdl/ioClkPkg.sv
`default_nettype none

package ioClkPkg;

    // Bus and configuration widths
    localparam int dataWidth    = 16;
    localparam int configWidth  = 16;
    localparam int divisorWidth = 14;
    localparam int modeWidth    = configWidth - divisorWidth;
    localparam int byteWidth    = 8;
    localparam int regDestWidth = 4;

    // Pending configuration queue
    localparam int queueDepth    = 4;
    localparam int queuePtrWidth = $clog2(queueDepth);
    localparam int queueCntWidth = $clog2(queueDepth + 1);

    // Output mode, taken from config bits 15:14
    typedef enum logic [modeWidth-1:0] {
        modeStop     = 2'd0,
        modeToggle   = 2'd1,
        modePulse    = 2'd2,
        // Treated the same as modeStop
        modeReserved = 2'd3
    } outMode_e;

    // Minor load opcode, other codes read back zero
    typedef enum logic [3:0] {
        opLoadWord  = 4'd0,
        opLoadByteU = 4'd1,
        opLoadByteS = 4'd2
    } loadOp_e;

endpackage

`default_nettype wire

//--- hdl/ioClkSubsystem.sv
`default_nettype none

module ioClkSubsystem (
    input  wire logic                               divided_clk_src,
    input  wire logic                               arstN,

    input  wire logic                               configAck,
    output logic                                    configReq,
    input  wire logic                               loadEn,
    input  var  ioClkPkg::loadOp_e                  minorOpcode,
    input  wire logic                               addrOffset,
    input  wire logic [ioClkPkg::configWidth-1:0]  configWord,
    input  wire logic [ioClkPkg::regDestWidth-1:0] regDest,

    output logic                                    responseAck,
    input  wire logic                               responseReq,
    output logic      [ioClkPkg::regDestWidth-1:0] responseRegDest,
    output logic      [ioClkPkg::dataWidth-1:0]    responseData,

    output logic                                    dividedClk,
    output ioClkPkg::outMode_e                      activeMode
);

    ioClkGenerationCell genCell (
        .divided_clk_src (divided_clk_src),
        .arstN           (arstN),
        .configAck       (configAck),
        .configReq       (configReq),
        .loadEn          (loadEn),
        .minorOpcode     (minorOpcode),
        .addrOffset      (addrOffset),
        .configWord      (configWord),
        .regDest         (regDest),
        .responseAck     (responseAck),
        .responseReq     (responseReq),
        .responseRegDest (responseRegDest),
        .responseData    (responseData),
        .dividedClk      (dividedClk),
        .activeMode      (activeMode)
    );

endmodule

`default_nettype wire

//--- hdl/loadDataAlignment.sv
`default_nettype none

module loadDataAlignment (
    input  var  ioClkPkg::loadOp_e               minorOpcode,
    input  wire logic                            addrOffset,
    input  wire logic [ioClkPkg::dataWidth-1:0] dataIn,
    output logic      [ioClkPkg::dataWidth-1:0] dataOut
);

    logic [ioClkPkg::byteWidth-1:0] byteSel;
    logic                           byteSign;

    // Offset 1 picks the upper byte
    always_comb begin
        if (addrOffset) begin
            byteSel = dataIn[2*ioClkPkg::byteWidth-1 -: ioClkPkg::byteWidth];
        end else begin
            byteSel = dataIn[ioClkPkg::byteWidth-1:0];
        end
    end

    assign byteSign = byteSel[ioClkPkg::byteWidth-1];

    always_comb begin
        case (minorOpcode)
            ioClkPkg::opLoadWord: begin
                dataOut = dataIn;
            end
            ioClkPkg::opLoadByteU: begin
                dataOut = {{(ioClkPkg::dataWidth - ioClkPkg::byteWidth){1'b0}}, byteSel};
            end
            ioClkPkg::opLoadByteS: begin
                dataOut = {{(ioClkPkg::dataWidth - ioClkPkg::byteWidth){byteSign}}, byteSel};
            end
            default: begin
                dataOut = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- ioClkGen.f
hdl/ioClkPkg.sv
hdl/loadDataAlignment.sv
hdl/configQueue.sv
hdl/clockDivider.sv
hdl/ioClkGenerationCell.sv
hdl/ioClkSubsystem.sv
verification/tbClockGen.sv
verification/tbIoClk.sv

//--- verification/tbClockGen.sv
`default_nettype none

module tbClockGen (
    output logic divided_clk_src,
    output logic arstN
);
    timeunit 1ns;
    timeprecision 100ps;

    // 40 ns period
    initial begin
        divided_clk_src = 1'b0;
        forever #20 divided_clk_src = !divided_clk_src;
    end

    // Reset held for two rising edges
    initial begin
        arstN = 1'b0;
        repeat (2) @(posedge divided_clk_src);
        #2 arstN = 1'b1;
    end

endmodule

`default_nettype wire

//--- verification/tbIoClk.sv
`default_nettype none

module tbIoClk;
    timeunit 1ns;
    timeprecision 100ps;

    logic                               divided_clk_src;
    logic                               arstN;
    logic                               configAck;
    logic                               configReq;
    logic                               loadEn;
    ioClkPkg::loadOp_e                  minorOpcode;
    logic                               addrOffset;
    logic [ioClkPkg::configWidth-1:0]  configWord;
    logic [ioClkPkg::regDestWidth-1:0] regDest;
    logic                               responseAck;
    logic                               responseReq;
    logic [ioClkPkg::regDestWidth-1:0] responseRegDest;
    logic [ioClkPkg::dataWidth-1:0]    responseData;
    logic                               dividedClk;
    ioClkPkg::outMode_e                 activeMode;

    // Reference model state
    logic [15:0] mCommitted;
    logic [15:0] mActive;
    logic [13:0] mCount;
    logic        mClk;
    logic [15:0] mQueue[$];

    logic sampledReq;
    logic sampledClk;
    int   errors;
    int   cycles;
    int   loads;

    tbClockGen clockSource (
        .divided_clk_src (divided_clk_src),
        .arstN           (arstN)
    );

    ioClkSubsystem i_dut (
        .divided_clk_src (divided_clk_src),
        .arstN           (arstN),
        .configAck       (configAck),
        .configReq       (configReq),
        .loadEn          (loadEn),
        .minorOpcode     (minorOpcode),
        .addrOffset      (addrOffset),
        .configWord      (configWord),
        .regDest         (regDest),
        .responseAck     (responseAck),
        .responseReq     (responseReq),
        .responseRegDest (responseRegDest),
        .responseData    (responseData),
        .dividedClk      (dividedClk),
        .activeMode      (activeMode)
    );

    function automatic logic [15:0] makeWord(ioClkPkg::outMode_e mode, logic [13:0] div);
        return {mode, div};
    endfunction

    // Byte select by offset, then word, zero or sign extension
    function automatic logic [15:0] expectLoad(logic [3:0] op, logic off, logic [15:0] word);
        logic [7:0] b;
        b = off ? word[15:8] : word[7:0];
        case (op)
            4'd0:    return word;
            4'd1:    return {8'h00, b};
            4'd2:    return {{8{b[7]}}, b};
            default: return 16'h0000;
        endcase
    endfunction

    // Mostly small divisors, any divisor when no waveform runs
    function automatic logic [15:0] randomConfig();
        logic [1:0]  mode;
        logic [13:0] div;
        mode = 2'($urandom % 4);
        if (mode == 2'd0 || mode == 2'd3) begin
            div = 14'($urandom);
        end else if ($urandom % 4 == 0) begin
            div = 14'($urandom % 64);
        end else begin
            div = 14'($urandom % 6);
        end
        return {mode, div};
    endfunction

    function automatic ioClkPkg::loadOp_e randomOpcode();
        logic [3:0] code;
        if ($urandom % 4 == 0) begin
            code = 4'($urandom % 16);
        end else begin
            code = 4'($urandom % 3);
        end
        return ioClkPkg::loadOp_e'(code);
    endfunction

    task automatic reportMismatch(input string name, input logic [15:0] expVal,
                                  input logic [15:0] actVal);
        $display("ERR t=%0t %s expected %h actual %h", $time, name, expVal, actVal);
        errors++;
    endtask

    // One clock edge of the model, with the inputs the DUT just sampled
    task automatic modelStep();
        ioClkPkg::outMode_e mode;
        logic               wrap;
        logic               adopt;
        logic               qFull;
        mode  = ioClkPkg::outMode_e'(mActive[15:14]);
        wrap  = (mCount == mActive[13:0]);
        qFull = (mQueue.size() == ioClkPkg::queueDepth);
        adopt = (mode == ioClkPkg::modeToggle || mode == ioClkPkg::modePulse) ? wrap : 1'b1;
        if (adopt && mQueue.size() != 0) begin
            mActive = mQueue.pop_front();
            mCount  = '0;
            mClk    = 1'b0;
        end else begin
            mCount = wrap ? '0 : mCount + 14'd1;
            case (mode)
                ioClkPkg::modeToggle: mClk = wrap ? !mClk : mClk;
                ioClkPkg::modePulse:  mClk = wrap;
                default:              mClk = 1'b0;
            endcase
        end
        if (configAck && !loadEn && !qFull) begin
            mCommitted = configWord;
            mQueue.push_back(configWord);
        end
    endtask

    // Check at the falling edge, then step to just after the next rising edge
    task automatic runCycle();
        logic        expReq;
        logic [15:0] expData;
        @(negedge divided_clk_src);
        cycles++;
        expReq = loadEn ? responseReq : (mQueue.size() < ioClkPkg::queueDepth);
        if (dividedClk !== mClk) begin
            reportMismatch("dividedClk", 16'(mClk), 16'(dividedClk));
        end
        if (activeMode !== ioClkPkg::outMode_e'(mActive[15:14])) begin
            reportMismatch("activeMode", 16'(mActive[15:14]), 16'(activeMode));
        end
        if (configReq !== expReq) begin
            reportMismatch("configReq", 16'(expReq), 16'(configReq));
        end
        if (responseAck !== (configAck && loadEn)) begin
            reportMismatch("responseAck", 16'(configAck && loadEn), 16'(responseAck));
        end
        if (responseRegDest !== regDest) begin
            reportMismatch("responseRegDest", 16'(regDest), 16'(responseRegDest));
        end
        if (configAck && loadEn && responseReq) begin
            loads++;
            expData = expectLoad(minorOpcode, addrOffset, mCommitted);
            if (responseData !== expData) begin
                reportMismatch("responseData", expData, responseData);
            end
        end
        sampledReq = configReq;
        sampledClk = dividedClk;
        @(posedge divided_clk_src);
        #2;
        modelStep();
    endtask

    task automatic driveIdle();
        configAck = 1'b0;
        loadEn    = 1'b0;
    endtask

    // Holds the write until configReq accepts it
    task automatic sendWrite(input logic [15:0] word, input int limit, output int held);
        held       = 0;
        configAck  = 1'b1;
        loadEn     = 1'b0;
        configWord = word;
        runCycle();
        while (!sampledReq && held < limit) begin
            held++;
            runCycle();
        end
        if (!sampledReq) begin
            $display("Timeout: write of %h was never accepted", word);
            errors++;
        end
    endtask

    task automatic waitForMode(input ioClkPkg::outMode_e mode, input int limit);
        int n;
        n = 0;
        while (activeMode !== mode && n < limit) begin
            runCycle();
            n++;
        end
        if (activeMode !== mode) begin
            $display("Timeout: activeMode never became %s", mode.name());
            errors++;
        end
    endtask

    // Cycles between two rising edges of dividedClk
    task automatic measurePeriod(input int expected, input string label);
        int   n;
        int   period;
        logic prevClk;
        n = 0;
        do begin
            prevClk = sampledClk;
            runCycle();
            n++;
        end while (!(sampledClk && !prevClk) && n < 200);
        if (!(sampledClk && !prevClk)) begin
            $display("Timeout: no rising edge of dividedClk in %s mode", label);
            errors++;
            return;
        end
        period = 0;
        do begin
            prevClk = sampledClk;
            runCycle();
            period++;
        end while (!(sampledClk && !prevClk) && period < 200);
        if (period != expected) begin
            $display("ERR t=%0t dividedClk %s period expected %0d actual %0d", $time, label,
                     expected, period);
            errors++;
        end
    endtask

    initial begin
        int held;
        int kind;
        int n;
        configAck   = 1'b0;
        loadEn      = 1'b0;
        minorOpcode = ioClkPkg::opLoadWord;
        addrOffset  = 1'b0;
        configWord  = '0;
        regDest     = '0;
        responseReq = 1'b0;
        mCommitted  = '0;
        mActive     = '0;
        mCount      = '0;
        mClk        = 1'b0;
        sampledReq  = 1'b0;
        sampledClk  = 1'b0;
        errors      = 0;
        cycles      = 0;
        loads       = 0;
        void'($urandom(32'he392_7597));

        n = 0;
        while (arstN !== 1'b1 && n < 10) begin
            @(posedge divided_clk_src);
            n++;
        end
        if (arstN !== 1'b1) begin
            $display("Timeout: reset was never released");
            errors++;
        end
        #2;
        modelStep();

        // Word load right after reset reads zero
        configAck   = 1'b1;
        loadEn      = 1'b1;
        responseReq = 1'b1;
        regDest     = 4'd5;
        runCycle();
        driveIdle();
        runCycle();

        sendWrite(makeWord(ioClkPkg::modeToggle, 14'd2), 20, held);
        driveIdle();
        waitForMode(ioClkPkg::modeToggle, 20);
        measurePeriod(6, "toggle");
        sendWrite(makeWord(ioClkPkg::modePulse, 14'd3), 20, held);
        driveIdle();
        waitForMode(ioClkPkg::modePulse, 20);
        measurePeriod(4, "pulse");

        // Long divisor keeps the queue from draining
        sendWrite(makeWord(ioClkPkg::modeToggle, 14'd40), 20, held);
        driveIdle();
        waitForMode(ioClkPkg::modeToggle, 20);
        for (int k = 0; k < 5; k++) begin
            sendWrite(makeWord(ioClkPkg::modeStop, 14'(k + 1)), 100, held);
            if (k < 4 && held != 0) begin
                $display("Write %0d was held off while the queue had room", k);
                errors++;
            end
            if (k == 4 && held == 0) begin
                $display("Fifth write was accepted while the queue was full");
                errors++;
            end
        end
        driveIdle();

        repeat (3000) begin
            kind        = int'($urandom % 10);
            responseReq = ($urandom % 4 != 0);
            if (kind < 3) begin
                configAck = 1'b0;
                loadEn    = 1'($urandom % 2);
            end else if (kind < 6) begin
                configAck  = 1'b1;
                loadEn     = 1'b0;
                configWord = randomConfig();
            end else begin
                configAck   = 1'b1;
                loadEn      = 1'b1;
                minorOpcode = randomOpcode();
                addrOffset  = 1'($urandom % 2);
                regDest     = 4'($urandom % 16);
            end
            runCycle();
        end
        driveIdle();
        runCycle();

        $display("Cycles %0d, loads %0d, errors %0d", cycles, loads, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
